//--- rtl/pm_defines.svh
`ifndef PM_DEFINES_SVH
`define PM_DEFINES_SVH

// Bus widths
`define PM_ADR_W        16
`define PM_DAT_W        32
`define PM_STRB_W       (`PM_DAT_W / 8)
`define PM_LB_REG_W     3               // Register index from address bits 4:2

// Work RAM of 4 KB in words
`define PM_RAM_ADR_W    10

`define PM_PIO_IN_W     8
`define PM_PIO_OUT_W    8

// Clock cycles per timer beat
`define PM_BEAT         25

`define PM_IRQ_N        4

// Address map, region in bits 15:14 and device in bits 11:8
`define PM_REGION_RAM   2'b10
`define PM_REGION_PER   2'b11
`define PM_DEV_PIO      4'd1
`define PM_DEV_TMR      4'd2
`define PM_DEV_IRQ      4'd3

// Register offsets
`define PM_PIO_REG_IN   3'd0
`define PM_PIO_REG_OUT  3'd1
`define PM_PIO_REG_SET  3'd2
`define PM_PIO_REG_CLR  3'd3
`define PM_PIO_REG_MSK  3'd4
`define PM_TMR_REG_CTL  3'd0
`define PM_TMR_REG_RLD  3'd1
`define PM_TMR_REG_CNT  3'd2
`define PM_IRQ_REG_EN   3'd0
`define PM_IRQ_REG_PND  3'd1

`endif

//--- rtl/pm_pkg.sv
`include "pm_defines.svh"

package pm_pkg;

    // Host byte address
    typedef logic [`PM_ADR_W-1:0]    adr_t;

    typedef logic [`PM_DAT_W-1:0]    dat_t;
    typedef logic [`PM_STRB_W-1:0]   strb_t;

    // Register index inside a device
    typedef logic [`PM_LB_REG_W-1:0] reg_t;

    // Decoded target of a host access
    typedef enum logic [2:0]
    {
        sel_none,
        sel_ram,
        sel_pio,
        sel_tmr,
        sel_irq
    } dev_sel_t;

    // Bit 0 PIO, bit 1 timer, bits 3:2 external
    typedef logic [`PM_IRQ_N-1:0]    irq_vec_t;

endpackage

//--- rtl/pm_lb_fabric.sv
`include "pm_defines.svh"

module pm_lb_fabric
(
    input  logic                     clk,
    input  logic                     arst_n,

    // Host port
    input  logic                     req,
    input  logic                     wr,
    input  pm_pkg::adr_t             adr,
    input  pm_pkg::dat_t             wdat,
    input  pm_pkg::strb_t            strb,
    output logic                     ack,
    output pm_pkg::dat_t             rdat,

    // Local bus to the devices
    output pm_pkg::reg_t             lb_reg,
    output pm_pkg::dat_t             lb_wdat,
    output pm_pkg::strb_t            lb_strb,
    output logic [`PM_RAM_ADR_W-1:0] ram_adr,
    output logic                     ram_wr,
    output logic                     ram_rd,
    output logic                     pio_wr,
    output logic                     pio_rd,
    output logic                     tmr_wr,
    output logic                     tmr_rd,
    output logic                     irq_wr,
    output logic                     irq_rd,
    input  pm_pkg::dat_t             ram_rdat,
    input  pm_pkg::dat_t             pio_rdat,
    input  pm_pkg::dat_t             tmr_rdat,
    input  pm_pkg::dat_t             irq_rdat
);

    typedef enum logic [1:0] {st_idle, st_strb, st_wait, st_ack} state_t;

    state_t            state;
    pm_pkg::dev_sel_t  sel_dec;
    pm_pkg::dev_sel_t  sel_q;
    logic              wr_q;
    pm_pkg::adr_t      adr_q;
    pm_pkg::dat_t      rdat_mux;

    // Region and device decode of the live host address
    always_comb
    begin
        sel_dec = pm_pkg::sel_none;
        if (adr[15:14] == `PM_REGION_RAM)
            sel_dec = pm_pkg::sel_ram;
        else if (adr[15:14] == `PM_REGION_PER)
        begin
            case (adr[11:8])
                `PM_DEV_PIO: sel_dec = pm_pkg::sel_pio;
                `PM_DEV_TMR: sel_dec = pm_pkg::sel_tmr;
                `PM_DEV_IRQ: sel_dec = pm_pkg::sel_irq;
                default:     sel_dec = pm_pkg::sel_none;
            endcase
        end
    end

    // Request fields captured once per access
    always_ff @(posedge clk)
    begin
        if (state == st_idle && req)
        begin
            wr_q    <= wr;
            adr_q   <= adr;
            lb_wdat <= wdat;
            lb_strb <= strb;
        end
        if (state == st_ack && !ack)
            rdat <= rdat_mux;       // Held while ack is high
    end

    assign lb_reg  = adr_q[2 +: `PM_LB_REG_W];
    assign ram_adr = adr_q[2 +: `PM_RAM_ADR_W];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= st_idle;
            sel_q  <= pm_pkg::sel_none;
            ack    <= 1'b0;
            ram_wr <= 1'b0;
            ram_rd <= 1'b0;
            pio_wr <= 1'b0;
            pio_rd <= 1'b0;
            tmr_wr <= 1'b0;
            tmr_rd <= 1'b0;
            irq_wr <= 1'b0;
            irq_rd <= 1'b0;
        end
        else
        begin
            // Strobes last one cycle
            ram_wr <= 1'b0;
            ram_rd <= 1'b0;
            pio_wr <= 1'b0;
            pio_rd <= 1'b0;
            tmr_wr <= 1'b0;
            tmr_rd <= 1'b0;
            irq_wr <= 1'b0;
            irq_rd <= 1'b0;
            case (state)
                st_idle:
                    if (req)
                    begin
                        sel_q <= sel_dec;
                        state <= st_strb;
                    end
                st_strb:
                begin
                    ram_wr <= wr_q && (sel_q == pm_pkg::sel_ram);
                    ram_rd <= !wr_q && (sel_q == pm_pkg::sel_ram);
                    pio_wr <= wr_q && (sel_q == pm_pkg::sel_pio);
                    pio_rd <= !wr_q && (sel_q == pm_pkg::sel_pio);
                    tmr_wr <= wr_q && (sel_q == pm_pkg::sel_tmr);
                    tmr_rd <= !wr_q && (sel_q == pm_pkg::sel_tmr);
                    irq_wr <= wr_q && (sel_q == pm_pkg::sel_irq);
                    irq_rd <= !wr_q && (sel_q == pm_pkg::sel_irq);
                    state  <= st_wait;
                end
                st_wait:
                    state <= st_ack;    // Device registers its read data
                default:
                    if (req)
                        ack <= 1'b1;
                    else
                    begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
            endcase
        end
    end

    // Unmapped reads return zero
    always_comb
    begin
        case (sel_q)
            pm_pkg::sel_ram: rdat_mux = ram_rdat;
            pm_pkg::sel_pio: rdat_mux = pio_rdat;
            pm_pkg::sel_tmr: rdat_mux = tmr_rdat;
            pm_pkg::sel_irq: rdat_mux = irq_rdat;
            default:         rdat_mux = '0;
        endcase
    end

    a_ack_rise_req : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req));

    a_one_strobe : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({ram_wr, ram_rd, pio_wr, pio_rd, tmr_wr, tmr_rd, irq_wr, irq_rd}));

endmodule

//--- rtl/pm_ram.sv
`include "pm_defines.svh"

module pm_ram
(
    input  logic                     clk,
    input  logic [`PM_RAM_ADR_W-1:0] ram_adr,
    input  pm_pkg::dat_t             lb_wdat,
    input  pm_pkg::strb_t            lb_strb,
    input  logic                     ram_wr,
    input  logic                     ram_rd,
    output pm_pkg::dat_t             ram_rdat
);

    localparam int DEPTH = 1 << `PM_RAM_ADR_W;

    pm_pkg::dat_t mem [0:DEPTH-1];

    // Byte lanes written under strobe
    always_ff @(posedge clk)
    begin
        if (ram_wr)
        begin
            for (int i = 0; i < `PM_STRB_W; i++)
            begin
                if (lb_strb[i])
                    mem[ram_adr][8*i +: 8] <= lb_wdat[8*i +: 8];
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (ram_rd)
            ram_rdat <= mem[ram_adr];
    end

    // Fabric serves one access at a time
    a_no_rd_wr : assert property (@(posedge clk)
        !(ram_wr && ram_rd));

endmodule

//--- rtl/pm_pio.sv
`include "pm_defines.svh"

module pm_pio
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  pm_pkg::reg_t             lb_reg,
    input  pm_pkg::dat_t             lb_wdat,
    input  logic                     pio_wr,
    input  logic                     pio_rd,
    output pm_pkg::dat_t             pio_rdat,
    input  logic [`PM_PIO_IN_W-1:0]  pio_in,
    output logic [`PM_PIO_OUT_W-1:0] pio_out,
    output logic                     irq
);

    logic [`PM_PIO_IN_W-1:0] in_meta;
    logic [`PM_PIO_IN_W-1:0] in_sync;
    logic [`PM_PIO_IN_W-1:0] in_prev;   // For edge detection
    logic [`PM_PIO_IN_W-1:0] rise_msk;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_meta  <= '0;
            in_sync  <= '0;
            in_prev  <= '0;
            rise_msk <= '0;
            pio_out  <= '0;
            irq      <= 1'b0;
        end
        else
        begin
            in_meta <= pio_in;
            in_sync <= in_meta;
            in_prev <= in_sync;
            irq     <= |(in_sync & ~in_prev & rise_msk);

            if (pio_wr)
            begin
                case (lb_reg)
                    `PM_PIO_REG_OUT: pio_out  <= lb_wdat[`PM_PIO_OUT_W-1:0];
                    `PM_PIO_REG_SET: pio_out  <= pio_out | lb_wdat[`PM_PIO_OUT_W-1:0];
                    `PM_PIO_REG_CLR: pio_out  <= pio_out & ~lb_wdat[`PM_PIO_OUT_W-1:0];
                    `PM_PIO_REG_MSK: rise_msk <= lb_wdat[`PM_PIO_IN_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Set and clear registers read zero
    always_ff @(posedge clk)
    begin
        if (pio_rd)
        begin
            case (lb_reg)
                `PM_PIO_REG_IN:  pio_rdat <= pm_pkg::dat_t'(in_sync);
                `PM_PIO_REG_OUT: pio_rdat <= pm_pkg::dat_t'(pio_out);
                `PM_PIO_REG_MSK: pio_rdat <= pm_pkg::dat_t'(rise_msk);
                default:         pio_rdat <= '0;
            endcase
        end
    end

endmodule

//--- rtl/pm_tmr.sv
`include "pm_defines.svh"

module pm_tmr
(
    input  logic         clk,
    input  logic         arst_n,
    input  pm_pkg::reg_t lb_reg,
    input  pm_pkg::dat_t lb_wdat,
    input  logic         tmr_wr,
    input  logic         tmr_rd,
    output pm_pkg::dat_t tmr_rdat,
    output logic         irq
);

    localparam int PRE_W = $clog2(`PM_BEAT);

    logic [PRE_W-1:0] pre_cnt;
    logic             beat;
    logic             en_r;
    logic             en_nxt;
    pm_pkg::dat_t     rld_r;
    pm_pkg::dat_t     cnt_r;

    assign beat = (pre_cnt == PRE_W'(`PM_BEAT - 1));

    // A disabling write silences a pulse due in the same cycle
    assign en_nxt = (tmr_wr && lb_reg == `PM_TMR_REG_CTL) ? lb_wdat[0] : en_r;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pre_cnt <= '0;
            en_r    <= 1'b0;
            rld_r   <= '0;
            cnt_r   <= '0;
            irq     <= 1'b0;
        end
        else
        begin
            irq  <= 1'b0;
            en_r <= en_nxt;
            if (tmr_wr && lb_reg == `PM_TMR_REG_RLD)
                rld_r <= lb_wdat;

            // Prescaler restarts with every enable
            if (!en_r)
            begin
                pre_cnt <= '0;
                cnt_r   <= rld_r;
            end
            else
            begin
                pre_cnt <= beat ? '0 : pre_cnt + 1'b1;
                if (beat)
                begin
                    if (cnt_r <= 1)
                    begin
                        irq   <= en_nxt;    // Count hits zero
                        cnt_r <= rld_r;
                    end
                    else
                        cnt_r <= cnt_r - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (tmr_rd)
        begin
            case (lb_reg)
                `PM_TMR_REG_CTL: tmr_rdat <= pm_pkg::dat_t'(en_r);
                `PM_TMR_REG_RLD: tmr_rdat <= rld_r;
                `PM_TMR_REG_CNT: tmr_rdat <= cnt_r;
                default:         tmr_rdat <= '0;
            endcase
        end
    end

    a_irq_enabled : assert property (@(posedge clk) disable iff (!arst_n)
        irq |-> en_r);

endmodule

//--- rtl/pm_irq.sv
`include "pm_defines.svh"

module pm_irq
(
    input  logic             clk,
    input  logic             arst_n,
    input  pm_pkg::reg_t     lb_reg,
    input  pm_pkg::dat_t     lb_wdat,
    input  logic             irq_wr,
    input  logic             irq_rd,
    output pm_pkg::dat_t     irq_rdat,
    input  pm_pkg::irq_vec_t irq_src,
    output logic             host_irq
);

    pm_pkg::irq_vec_t en_r;
    pm_pkg::irq_vec_t pnd_r;
    pm_pkg::irq_vec_t pnd_clr;

    // Write one to clear
    assign pnd_clr = (irq_wr && lb_reg == `PM_IRQ_REG_PND) ?
                     lb_wdat[`PM_IRQ_N-1:0] : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            en_r     <= '0;
            pnd_r    <= '0;
            host_irq <= 1'b0;
        end
        else
        begin
            if (irq_wr && lb_reg == `PM_IRQ_REG_EN)
                en_r <= lb_wdat[`PM_IRQ_N-1:0];
            pnd_r    <= (pnd_r & ~pnd_clr) | irq_src;   // Set wins over clear
            host_irq <= |(pnd_r & en_r);
        end
    end

    always_ff @(posedge clk)
    begin
        if (irq_rd)
        begin
            case (lb_reg)
                `PM_IRQ_REG_EN:  irq_rdat <= pm_pkg::dat_t'(en_r);
                `PM_IRQ_REG_PND: irq_rdat <= pm_pkg::dat_t'(pnd_r);
                default:         irq_rdat <= '0;
            endcase
        end
    end

endmodule

//--- rtl/pm_top.sv
`include "pm_defines.svh"

module pm_top
(
    input  logic                     clk,
    input  logic                     arst_n,

    // Host port
    input  logic                     req,
    input  logic                     wr,
    input  pm_pkg::adr_t             adr,
    input  pm_pkg::dat_t             wdat,
    input  pm_pkg::strb_t            strb,
    output logic                     ack,
    output pm_pkg::dat_t             rdat,

    input  logic [`PM_PIO_IN_W-1:0]  pio_in,
    output logic [`PM_PIO_OUT_W-1:0] pio_out,
    input  logic [1:0]               irq_in,    // External requests
    output logic                     host_irq
);

    pm_pkg::reg_t             lb_reg;
    pm_pkg::dat_t             lb_wdat;
    pm_pkg::strb_t            lb_strb;
    logic [`PM_RAM_ADR_W-1:0] ram_adr;
    logic                     ram_wr, ram_rd;
    logic                     pio_wr, pio_rd;
    logic                     tmr_wr, tmr_rd;
    logic                     irq_wr, irq_rd;
    pm_pkg::dat_t             ram_rdat, pio_rdat, tmr_rdat, irq_rdat;
    logic                     pio_irq;
    logic                     tmr_irq;
    pm_pkg::irq_vec_t         irq_src;

    assign irq_src = {irq_in, tmr_irq, pio_irq};

    pm_lb_fabric i_fabric
    (
        .clk      (clk),      .arst_n   (arst_n),
        .req      (req),      .wr       (wr),       .adr      (adr),
        .wdat     (wdat),     .strb     (strb),     .ack      (ack),
        .rdat     (rdat),     .lb_reg   (lb_reg),   .lb_wdat  (lb_wdat),
        .lb_strb  (lb_strb),  .ram_adr  (ram_adr),
        .ram_wr   (ram_wr),   .ram_rd   (ram_rd),   .pio_wr   (pio_wr),
        .pio_rd   (pio_rd),   .tmr_wr   (tmr_wr),   .tmr_rd   (tmr_rd),
        .irq_wr   (irq_wr),   .irq_rd   (irq_rd),   .ram_rdat (ram_rdat),
        .pio_rdat (pio_rdat), .tmr_rdat (tmr_rdat), .irq_rdat (irq_rdat)
    );

    pm_ram i_ram
    (
        .clk      (clk),      .ram_adr  (ram_adr),  .lb_wdat  (lb_wdat),
        .lb_strb  (lb_strb),  .ram_wr   (ram_wr),   .ram_rd   (ram_rd),
        .ram_rdat (ram_rdat)
    );

    pm_pio i_pio
    (
        .clk      (clk),      .arst_n   (arst_n),   .lb_reg   (lb_reg),
        .lb_wdat  (lb_wdat),  .pio_wr   (pio_wr),   .pio_rd   (pio_rd),
        .pio_rdat (pio_rdat), .pio_in   (pio_in),   .pio_out  (pio_out),
        .irq      (pio_irq)
    );

    pm_tmr i_tmr
    (
        .clk      (clk),      .arst_n   (arst_n),   .lb_reg   (lb_reg),
        .lb_wdat  (lb_wdat),  .tmr_wr   (tmr_wr),   .tmr_rd   (tmr_rd),
        .tmr_rdat (tmr_rdat), .irq      (tmr_irq)
    );

    pm_irq i_irq
    (
        .clk      (clk),      .arst_n   (arst_n),   .lb_reg   (lb_reg),
        .lb_wdat  (lb_wdat),  .irq_wr   (irq_wr),   .irq_rd   (irq_rd),
        .irq_rdat (irq_rdat), .irq_src  (irq_src),  .host_irq (host_irq)
    );

endmodule

//--- verification/tb_pm_top.sv
`include "pm_defines.svh"

module tb_pm_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime CLK_PER = 4.0;
    localparam realtime DRV_DLY = 0.5;
    localparam int ACK_LAT   = 3;
    localparam int ACK_LIMIT = 16;
    localparam int N_RAM     = 200;
    localparam int N_HS      = 60;
    localparam int N_PIO     = 60;
    localparam int N_PIN     = 20;
    localparam int N_EDGE    = 8;
    localparam int N_TMR     = 3;
    localparam int N_EXT     = 8;
    localparam int MAX_RLD   = 4;

    // Host accesses and idle waits per test summed for the watchdog
    localparam int ACC_CYC    = ACK_LIMIT + 2;
    localparam int ACC_TOTAL  = 3 * N_RAM + N_HS + 10 + 2 * N_PIO + N_PIN + 2
                                + 4 * N_EDGE + 1 + 8 * N_TMR + 1 + 3 * N_EXT;
    localparam int WAIT_TOTAL = 2 * N_PIN + 4 + 28 * N_EDGE + 3 * N_EXT
                                + N_TMR * ((2 * MAX_RLD + 3) * `PM_BEAT + 16);
    localparam realtime WATCHDOG = 2.0 * (ACC_TOTAL * ACC_CYC + WAIT_TOTAL + 4) * CLK_PER;

    logic                     clk;
    logic                     arst_n;
    logic                     req;
    logic                     wr;
    pm_pkg::adr_t             adr;
    pm_pkg::dat_t             wdat;
    pm_pkg::strb_t            strb;
    logic                     ack;
    pm_pkg::dat_t             rdat;
    logic [`PM_PIO_IN_W-1:0]  pio_in;
    logic [`PM_PIO_OUT_W-1:0] pio_out;
    logic [1:0]               irq_in;
    logic                     host_irq;

    // Reference model state
    pm_pkg::dat_t             ram_model [0:(1 << `PM_RAM_ADR_W)-1];
    logic [`PM_RAM_ADR_W-1:0] ram_list [N_RAM];
    logic [`PM_PIO_OUT_W-1:0] out_model;
    pm_pkg::irq_vec_t         en_model;
    pm_pkg::irq_vec_t         pnd_model;

    int err_cnt  = 0;
    int chk_cnt  = 0;
    int test_cnt = 0;
    int err_mark = 0;

    pm_top i_dut
    (
        .clk      (clk),      .arst_n   (arst_n),
        .req      (req),      .wr       (wr),       .adr      (adr),
        .wdat     (wdat),     .strb     (strb),     .ack      (ack),
        .rdat     (rdat),     .pio_in   (pio_in),   .pio_out  (pio_out),
        .irq_in   (irq_in),   .host_irq (host_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired at %0t, the run did not complete", $time);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_dat(input string name, input pm_pkg::dat_t got, input pm_pkg::dat_t exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_out(input string name, input logic [`PM_PIO_OUT_W-1:0] got,
                             input logic [`PM_PIO_OUT_W-1:0] exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    // Four-phase access entered and left just after a rising edge
    task automatic bus_access(input logic is_wr, input pm_pkg::adr_t a, input pm_pkg::dat_t d,
                              input pm_pkg::strb_t s, output pm_pkg::dat_t q);
        int lat;
        wr   = is_wr;
        adr  = a;
        wdat = d;
        strb = s;
        req  = 1'b1;
        lat  = 0;
        while (!ack && lat < ACK_LIMIT)
        begin
            @(posedge clk);
            #DRV_DLY;
            lat++;
            if (lat <= ACK_LAT + 1)
                check_bit("ack", ack, lat == ACK_LAT + 1);  // Sampling edge plus three
        end
        if (!ack)
        begin
            err_cnt++;
            $display("error at %0t: no acknowledge for access to %h", $time, a);
        end
        q   = rdat;
        req = 1'b0;
        wait_cycles(1);
        check_bit("ack", ack, 1'b0);
    endtask

    task automatic bus_write(input pm_pkg::adr_t a, input pm_pkg::dat_t d, input pm_pkg::strb_t s);
        pm_pkg::dat_t unused;
        bus_access(1'b1, a, d, s, unused);
    endtask

    task automatic bus_read(input pm_pkg::adr_t a, output pm_pkg::dat_t q);
        bus_access(1'b0, a, '0, '0, q);
    endtask

    task automatic wait_host_irq(input int limit);
        int n;
        n = 0;
        while (!host_irq && n < limit)
        begin
            @(posedge clk);
            #DRV_DLY;
            n++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %s %s (%0d errors)", name, (err_cnt == err_mark) ? "ok" : "FAILED",
                 err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    // Mirror bits 13:12 are random since the decode ignores them
    function automatic pm_pkg::adr_t ram_byte_adr(input logic [`PM_RAM_ADR_W-1:0] w);
        logic [1:0] mirror;
        mirror = 2'($urandom);
        return {`PM_REGION_RAM, mirror, w, 2'b00};
    endfunction

    function automatic pm_pkg::adr_t reg_adr(input logic [3:0] dev, input pm_pkg::reg_t r);
        return {`PM_REGION_PER, 2'b00, dev, 3'b000, r, 2'b00};
    endfunction

    function automatic logic is_mapped(input pm_pkg::adr_t a);
        if (a[15:14] == `PM_REGION_RAM)
            return 1'b1;
        return a[15:14] == `PM_REGION_PER &&
               (a[11:8] == `PM_DEV_PIO || a[11:8] == `PM_DEV_TMR || a[11:8] == `PM_DEV_IRQ);
    endfunction

    function automatic pm_pkg::dat_t fill_word(input logic [`PM_RAM_ADR_W-1:0] w);
        return {~w[7:0], w, 4'h5, w};
    endfunction

    function automatic pm_pkg::dat_t merge_bytes(input pm_pkg::dat_t old, input pm_pkg::dat_t d,
                                                 input pm_pkg::strb_t s);
        pm_pkg::dat_t res;
        res = old;
        for (int i = 0; i < 4; i++)
            if (s[i])
                res[8*i +: 8] = d[8*i +: 8];
        return res;
    endfunction

    initial
    begin
        pm_pkg::dat_t             q;
        pm_pkg::dat_t             d;
        pm_pkg::strb_t            s;
        pm_pkg::adr_t             a;
        logic [`PM_RAM_ADR_W-1:0] w;
        logic [`PM_PIO_IN_W-1:0]  pin;
        logic [1:0]               src;
        pm_pkg::reg_t             r;
        int                       b;
        int                       c;
        int                       n;
        int                       elapsed;
        realtime                  t_en;

        void'($urandom(32'he803));
        arst_n = 1'b0;
        req    = 1'b0;
        wr     = 1'b0;
        adr    = '0;
        wdat   = '0;
        strb   = '0;
        pio_in = '0;
        irq_in = '0;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        arst_n = 1'b1;
        check_bit("ack", ack, 1'b0);
        check_bit("host_irq", host_irq, 1'b0);
        check_out("pio_out", pio_out, '0);
        finish_test("reset");

        // Whole words first so unstrobed bytes are known
        for (int i = 0; i < N_RAM; i++)
        begin
            ram_list[i] = $urandom;
            ram_model[ram_list[i]] = fill_word(ram_list[i]);
            bus_write(ram_byte_adr(ram_list[i]), ram_model[ram_list[i]], 4'hf);
        end
        for (int i = 0; i < N_RAM; i++)
        begin
            w = ram_list[i];
            d = $urandom;
            s = pm_pkg::strb_t'($urandom);
            bus_write(ram_byte_adr(w), d, s);
            ram_model[w] = merge_bytes(ram_model[w], d, s);
        end
        for (int i = 0; i < N_RAM; i++)
        begin
            bus_read(ram_byte_adr(ram_list[i]), q);
            check_dat("rdat", q, ram_model[ram_list[i]]);
        end
        finish_test("ram");

        for (int i = 0; i < N_HS; i++)
        begin
            a = $urandom;
            while (is_mapped(a))
                a = $urandom;
            if ($urandom % 2)
                bus_write(a, $urandom, pm_pkg::strb_t'($urandom));
            else
            begin
                bus_read(a, q);
                check_dat("rdat", q, '0);
            end
        end
        for (int i = 0; i < 10; i++)
        begin
            w = ram_list[$urandom % N_RAM];
            bus_read(ram_byte_adr(w), q);
            check_dat("rdat", q, ram_model[w]);     // Unmapped writes went nowhere
        end
        finish_test("handshake");

        out_model = '0;
        for (int i = 0; i < N_PIO; i++)
        begin
            d = $urandom;
            case ($urandom % 3)
                0:
                begin
                    r = `PM_PIO_REG_OUT;
                    out_model = d[`PM_PIO_OUT_W-1:0];
                end
                1:
                begin
                    r = `PM_PIO_REG_SET;
                    out_model = out_model | d[`PM_PIO_OUT_W-1:0];
                end
                default:
                begin
                    r = `PM_PIO_REG_CLR;
                    out_model = out_model & ~d[`PM_PIO_OUT_W-1:0];
                end
            endcase
            bus_write(reg_adr(`PM_DEV_PIO, r), d, 4'hf);
            check_out("pio_out", pio_out, out_model);
            bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_REG_OUT), q);
            check_dat("rdat", q, pm_pkg::dat_t'(out_model));
        end
        for (int i = 0; i < N_PIN; i++)
        begin
            pin    = $urandom;
            pio_in = pin;
            wait_cycles(2);     // Two-flop synchronizer
            bus_read(reg_adr(`PM_DEV_PIO, `PM_PIO_REG_IN), q);
            check_dat("rdat", q, pm_pkg::dat_t'(pin));
        end
        finish_test("pio");

        pio_in = '0;
        wait_cycles(4);
        en_model  = 4'b0001;
        pnd_model = '0;
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_EN), pm_pkg::dat_t'(en_model), 4'hf);
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'hf, 4'hf);
        for (int i = 0; i < N_EDGE; i++)
        begin
            b = $urandom % `PM_PIO_IN_W;
            c = (b + 1 + $urandom % (`PM_PIO_IN_W - 1)) % `PM_PIO_IN_W;
            bus_write(reg_adr(`PM_DEV_PIO, `PM_PIO_REG_MSK), 32'(1) << b, 4'hf);
            pio_in = 8'(1) << b;
            wait_host_irq(16);
            pnd_model[0] = 1'b1;
            check_bit("host_irq", host_irq, 1'b1);
            bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), q);
            check_dat("rdat", q, pm_pkg::dat_t'(pnd_model));
            bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'h1, 4'hf);
            pnd_model[0] = 1'b0;
            check_bit("host_irq", host_irq, 1'b0);
            pio_in = pio_in | (8'(1) << c);     // Unmasked rise
            wait_cycles(8);
            check_bit("host_irq", host_irq, 1'b0);
            bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), q);
            check_dat("rdat", q, pm_pkg::dat_t'(pnd_model));
            pio_in = '0;
            wait_cycles(4);
        end
        finish_test("pio_irq");

        en_model = 4'b0010;
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_EN), pm_pkg::dat_t'(en_model), 4'hf);
        for (int i = 0; i < N_TMR; i++)
        begin
            n = 1 + $urandom % MAX_RLD;
            bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'hf, 4'hf);
            bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_REG_RLD), n, 4'hf);
            bus_read(reg_adr(`PM_DEV_TMR, `PM_TMR_REG_RLD), q);
            check_dat("rdat", q, pm_pkg::dat_t'(n));
            t_en = $realtime;
            bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_REG_CTL), 32'h1, 4'hf);
            wait_host_irq((n + 1) * `PM_BEAT + 16);
            elapsed = int'(($realtime - t_en) / CLK_PER);
            if (!host_irq)
            begin
                err_cnt++;
                $display("error at %0t: no timer interrupt with reload %0d", $time, n);
            end
            else if (elapsed < n * `PM_BEAT || elapsed > (n + 1) * `PM_BEAT + 8)
            begin
                err_cnt++;
                $display("error at %0t: timer interrupt after %0d cycles, allowed %0d to %0d",
                         $time, elapsed, n * `PM_BEAT, (n + 1) * `PM_BEAT + 8);
            end
            bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), q);
            check_dat("rdat", q, 32'h2);
            // Disable before clearing so no late pulse survives
            bus_write(reg_adr(`PM_DEV_TMR, `PM_TMR_REG_CTL), 32'h0, 4'hf);
            bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'hf, 4'hf);
            wait_cycles((n + 2) * `PM_BEAT);
            check_bit("host_irq", host_irq, 1'b0);
            bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), q);
            check_dat("rdat", q, '0);
        end
        finish_test("timer");

        pnd_model = '0;
        bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'hf, 4'hf);
        for (int i = 0; i < N_EXT; i++)
        begin
            en_model = {2'($urandom), 2'b00};
            bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_EN), pm_pkg::dat_t'(en_model), 4'hf);
            src    = 2'(1 + $urandom % 3);
            irq_in = src;
            wait_cycles(1);
            irq_in = '0;
            wait_cycles(2);
            pnd_model = {src, 2'b00};
            check_bit("host_irq", host_irq, |(pnd_model & en_model));
            bus_read(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), q);
            check_dat("rdat", q, pm_pkg::dat_t'(pnd_model));
            bus_write(reg_adr(`PM_DEV_IRQ, `PM_IRQ_REG_PND), 32'hf, 4'hf);
            pnd_model = '0;
            check_bit("host_irq", host_irq, 1'b0);
        end
        finish_test("ext_irq");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/pm_pkg.sv
rtl/pm_lb_fabric.sv
rtl/pm_ram.sv
rtl/pm_pio.sv
rtl/pm_tmr.sv
rtl/pm_irq.sv
rtl/pm_top.sv
verification/tb_pm_top.sv
